// ==== design/wbSramPkg.sv ====
`default_nettype none

package wbSramPkg;

	// Region codes produced by the bridge address decoder.
	localparam logic [1:0] REGION_SRAM = 2'd0;
	localparam logic [1:0] REGION_MGMT = 2'd1;
	localparam logic [1:0] REGION_NONE = 2'd2;

	// Address nibble 23:20 that selects the management bank.
	localparam logic [3:0] MGMT_REGION = 4'h8;

	// The SRAM decodes only the low word-address bits, so the rest alias.
	localparam int SRAM_ADDR_BITS = 8;
	localparam int SRAM_WORDS = 1 << SRAM_ADDR_BITS;

	// Busy cycles added by the SRAM to every access.
	localparam int SRAM_WAIT_CYCLES = 2;
	localparam int SRAM_WAIT_BITS = 2;
	localparam logic [SRAM_WAIT_BITS-1:0] SRAM_WAIT_LOAD =
		SRAM_WAIT_BITS'(SRAM_WAIT_CYCLES - 1);

	// Register 0 is the core identity, the others are scratch.
	localparam int MGMT_REG_COUNT = 8;

	typedef enum logic [1:0] {
		STATE_IDLE,
		STATE_WRITE_SINGLE,
		STATE_READ_SINGLE,
		STATE_FINISH
	} busState;

endpackage

`default_nettype wire

// ==== design/wbSramInterface.sv ====
`timescale 1ns/1ps
`default_nettype none

module wbSramInterface (
	input wire wb_clk_i,
	input wire wb_rst_i,

	input wire wb_cyc_i,
	input wire wb_stb_i,
	input wire wb_we_i,
	input wire [3:0] wb_sel_i,
	input wire [23:0] wb_adr_i,
	input wire [31:0] wb_data_i,
	output logic wb_ack_o,
	output logic wb_stall_o,
	output logic wb_error_o,
	output logic [31:0] wb_data_o,

	output logic sramWriteEnable_o,
	output logic sramReadEnable_o,
	output logic [23:0] sramAddress_o,
	output logic [3:0] sramByteSelect_o,

	output logic mgmtWriteEnable_o,
	output logic mgmtReadEnable_o,
	output logic [19:0] mgmtAddress_o,
	output logic [3:0] mgmtByteSelect_o,

	output logic [31:0] writeData_o,

	input wire [31:0] sramReadData_i,
	input wire sramBusy_i,
	input wire [31:0] mgmtReadData_i,
	input wire mgmtBusy_i
);

	wbSramPkg::busState state;

	logic [23:0] currentAddress;
	logic [3:0] currentByteSelect;
	logic [31:0] currentDataIn;
	logic [1:0] regionCode;

	logic [31:0] selectedReadData;
	logic selectedBusy;

	logic isWrite;
	logic isRead;
	logic isActive;
	logic accept;

	assign accept = wb_cyc_i && wb_stb_i && !wb_stall_o && (state == wbSramPkg::STATE_IDLE);

	assign isWrite = state == wbSramPkg::STATE_WRITE_SINGLE;
	assign isRead = state == wbSramPkg::STATE_READ_SINGLE;
	assign isActive = state != wbSramPkg::STATE_IDLE;

	// The request is held here for the whole access.
	always_ff @(posedge wb_clk_i) begin
		if (accept) begin
			currentAddress <= wb_adr_i;
			currentByteSelect <= wb_sel_i;
			currentDataIn <= wb_data_i;
		end
	end

	// Decode works on the held address so a master changing its bus mid-access is harmless.
	always_comb begin
		if (!currentAddress[23]) begin
			regionCode = wbSramPkg::REGION_SRAM;
		end else if (currentAddress[23:20] == wbSramPkg::MGMT_REGION) begin
			regionCode = wbSramPkg::REGION_MGMT;
		end else begin
			regionCode = wbSramPkg::REGION_NONE;
		end
	end

	always_comb begin
		case (regionCode)
			wbSramPkg::REGION_SRAM: begin
				selectedReadData = sramReadData_i;
				selectedBusy = sramBusy_i;
			end
			wbSramPkg::REGION_MGMT: begin
				selectedReadData = mgmtReadData_i;
				selectedBusy = mgmtBusy_i;
			end
			default: begin
				selectedReadData = 32'd0;
				selectedBusy = 1'b0;
			end
		endcase
	end

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			state <= wbSramPkg::STATE_IDLE;
			wb_stall_o <= 1'b0;
			wb_ack_o <= 1'b0;
			wb_error_o <= 1'b0;
			wb_data_o <= 32'd0;
		end else begin
			case (state)
				wbSramPkg::STATE_IDLE: begin
					if (accept) begin
						wb_stall_o <= 1'b1;
						state <= wb_we_i ? wbSramPkg::STATE_WRITE_SINGLE
							: wbSramPkg::STATE_READ_SINGLE;
					end
				end

				wbSramPkg::STATE_WRITE_SINGLE, wbSramPkg::STATE_READ_SINGLE: begin
					if (regionCode == wbSramPkg::REGION_NONE) begin
						state <= wbSramPkg::STATE_FINISH;
						wb_error_o <= 1'b1;
					end else if (!selectedBusy) begin
						state <= wbSramPkg::STATE_FINISH;
						wb_ack_o <= 1'b1;
						if (isRead) begin
							wb_data_o <= selectedReadData;
						end
					end
				end

				wbSramPkg::STATE_FINISH: begin
					state <= wbSramPkg::STATE_IDLE;
					wb_ack_o <= 1'b0;
					wb_error_o <= 1'b0;
					wb_stall_o <= 1'b0;
				end

				default: begin
					state <= wbSramPkg::STATE_IDLE;
				end
			endcase
		end
	end

	assign sramWriteEnable_o = isWrite && (regionCode == wbSramPkg::REGION_SRAM);
	assign sramReadEnable_o = isRead && (regionCode == wbSramPkg::REGION_SRAM);
	assign mgmtWriteEnable_o = isWrite && (regionCode == wbSramPkg::REGION_MGMT);
	assign mgmtReadEnable_o = isRead && (regionCode == wbSramPkg::REGION_MGMT);

	assign sramAddress_o = isActive ? currentAddress : 24'd0;
	assign sramByteSelect_o = isActive ? currentByteSelect : 4'd0;
	assign mgmtAddress_o = isActive ? currentAddress[19:0] : 20'd0;
	assign mgmtByteSelect_o = isActive ? currentByteSelect : 4'd0;
	assign writeData_o = isWrite ? currentDataIn : 32'd0;

endmodule

`default_nettype wire

// ==== design/localSram.sv ====
`timescale 1ns/1ps
`default_nettype none

module localSram (
	input wire wb_clk_i,
	input wire wb_rst_i,
	input wire writeEnable_i,
	input wire readEnable_i,
	input wire [23:0] address_i,
	input wire [3:0] byteSelect_i,
	input wire [31:0] writeData_i,
	output logic [31:0] readData_o,
	output logic busy_o
);

	logic [31:0] memory [0:wbSramPkg::SRAM_WORDS-1];

	logic [wbSramPkg::SRAM_ADDR_BITS-1:0] wordIndex;
	logic [wbSramPkg::SRAM_WAIT_BITS-1:0] waitCount;
	logic waitLoaded;
	logic anyEnable;
	logic complete;

	assign wordIndex = address_i[wbSramPkg::SRAM_ADDR_BITS-1:0];
	assign anyEnable = writeEnable_i || readEnable_i;

	// Busy is raised combinationally on the first enable cycle, before the counter has loaded.
	assign busy_o = anyEnable && (!waitLoaded || (waitCount != '0));
	assign complete = anyEnable && !busy_o;

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			waitLoaded <= 1'b0;
			waitCount <= '0;
		end else if (!anyEnable) begin
			waitLoaded <= 1'b0;
			waitCount <= '0;
		end else if (!waitLoaded) begin
			waitLoaded <= 1'b1;
			waitCount <= wbSramPkg::SRAM_WAIT_LOAD;
		end else if (waitCount != '0) begin
			waitCount <= waitCount - 1'b1;
		end
	end

	// Only the selected byte lanes change.
	always_ff @(posedge wb_clk_i) begin
		if (writeEnable_i && complete) begin
			for (int lane = 0; lane < 4; lane++) begin
				if (byteSelect_i[lane]) begin
					memory[wordIndex][lane*8 +: 8] <= writeData_i[lane*8 +: 8];
				end
			end
		end
	end

	always_comb begin
		if (readEnable_i && complete) begin
			readData_o = memory[wordIndex];
		end else begin
			readData_o = 32'd0;
		end
	end

endmodule

`default_nettype wire

// ==== design/managementRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

module managementRegs (
	input wire wb_clk_i,
	input wire wb_rst_i,
	input wire writeEnable_i,
	input wire readEnable_i,
	input wire [19:0] address_i,
	input wire [3:0] byteSelect_i,
	input wire [31:0] writeData_i,
	input wire [3:0] coreId_i,
	output logic [31:0] readData_o,
	output logic busy_o
);

	// Index 0 is the identity word, so the array starts at 1.
	logic [31:0] scratchRegs [1:wbSramPkg::MGMT_REG_COUNT-1];

	logic [2:0] regIndex;
	logic anyEnable;
	logic accessStarted;
	logic [31:0] selectedWord;

	assign regIndex = address_i[2:0];
	assign anyEnable = writeEnable_i || readEnable_i;

	// The bank needs one cycle to settle, so busy covers only the first enable cycle.
	assign busy_o = anyEnable && !accessStarted;

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			accessStarted <= 1'b0;
		end else begin
			accessStarted <= anyEnable;
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			for (int i = 1; i < wbSramPkg::MGMT_REG_COUNT; i++) begin
				scratchRegs[i] <= 32'd0;
			end
		end else if (writeEnable_i && accessStarted && (regIndex != 3'd0)) begin
			for (int lane = 0; lane < 4; lane++) begin
				if (byteSelect_i[lane]) begin
					scratchRegs[regIndex][lane*8 +: 8] <= writeData_i[lane*8 +: 8];
				end
			end
		end
	end

	always_comb begin
		if (regIndex == 3'd0) begin
			selectedWord = {28'd0, coreId_i};
		end else begin
			selectedWord = scratchRegs[regIndex];
		end
	end

	// Read data is only put out on the completing cycle.
	always_comb begin
		if (readEnable_i && accessStarted) begin
			readData_o = selectedWord;
		end else begin
			readData_o = 32'd0;
		end
	end

endmodule

`default_nettype wire

// ==== design/wbSramTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module wbSramTop (
	input wire wb_clk_i,
	input wire wb_rst_i,
	input wire wb_cyc_i,
	input wire wb_stb_i,
	input wire wb_we_i,
	input wire [3:0] wb_sel_i,
	input wire [23:0] wb_adr_i,
	input wire [31:0] wb_data_i,
	output wire wb_ack_o,
	output wire wb_stall_o,
	output wire wb_error_o,
	output wire [31:0] wb_data_o,
	input wire [3:0] coreId_i
);

	wire sramWriteEnable;
	wire sramReadEnable;
	wire [23:0] sramAddress;
	wire [3:0] sramByteSelect;
	wire [31:0] sramReadData;
	wire sramBusy;

	wire mgmtWriteEnable;
	wire mgmtReadEnable;
	wire [19:0] mgmtAddress;
	wire [3:0] mgmtByteSelect;
	wire [31:0] mgmtReadData;
	wire mgmtBusy;

	// Both back ends see the same write data.
	wire [31:0] writeData;

	wbSramInterface u_wbSramInterface (
		.wb_clk_i(wb_clk_i),
		.wb_rst_i(wb_rst_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_we_i(wb_we_i),
		.wb_sel_i(wb_sel_i),
		.wb_adr_i(wb_adr_i),
		.wb_data_i(wb_data_i),
		.wb_ack_o(wb_ack_o),
		.wb_stall_o(wb_stall_o),
		.wb_error_o(wb_error_o),
		.wb_data_o(wb_data_o),
		.sramWriteEnable_o(sramWriteEnable),
		.sramReadEnable_o(sramReadEnable),
		.sramAddress_o(sramAddress),
		.sramByteSelect_o(sramByteSelect),
		.mgmtWriteEnable_o(mgmtWriteEnable),
		.mgmtReadEnable_o(mgmtReadEnable),
		.mgmtAddress_o(mgmtAddress),
		.mgmtByteSelect_o(mgmtByteSelect),
		.writeData_o(writeData),
		.sramReadData_i(sramReadData),
		.sramBusy_i(sramBusy),
		.mgmtReadData_i(mgmtReadData),
		.mgmtBusy_i(mgmtBusy)
	);

	localSram u_localSram (
		.wb_clk_i(wb_clk_i),
		.wb_rst_i(wb_rst_i),
		.writeEnable_i(sramWriteEnable),
		.readEnable_i(sramReadEnable),
		.address_i(sramAddress),
		.byteSelect_i(sramByteSelect),
		.writeData_i(writeData),
		.readData_o(sramReadData),
		.busy_o(sramBusy)
	);

	managementRegs u_managementRegs (
		.wb_clk_i(wb_clk_i),
		.wb_rst_i(wb_rst_i),
		.writeEnable_i(mgmtWriteEnable),
		.readEnable_i(mgmtReadEnable),
		.address_i(mgmtAddress),
		.byteSelect_i(mgmtByteSelect),
		.writeData_i(writeData),
		.coreId_i(coreId_i),
		.readData_o(mgmtReadData),
		.busy_o(mgmtBusy)
	);

endmodule

`default_nettype wire

// ==== tb/wbSram_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module wbSramAsserts (
	input wire wb_clk_i,
	input wire wb_rst_i,
	input wire ack_i,
	input wire error_i,
	input wire stall_i,
	input wire sramWriteEnable_i,
	input wire sramReadEnable_i,
	input wire mgmtWriteEnable_i,
	input wire mgmtReadEnable_i
);

	ackErrorExclusive: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		!(ack_i && error_i))
		else $error("ack and error are high in the same cycle");

	ackSingleCycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		ack_i |=> !ack_i)
		else $error("ack is high for two cycles running");

	enablesOneHot: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		$onehot0({sramWriteEnable_i, sramReadEnable_i, mgmtWriteEnable_i, mgmtReadEnable_i}))
		else $error("more than one back-end enable is high");

	resetQuiet: assert property (@(posedge wb_clk_i)
		wb_rst_i |=> !stall_i && !ack_i)
		else $error("stall or ack is high after a reset cycle");

endmodule

bind wbSramInterface wbSramAsserts u_wbSramAsserts (
	.wb_clk_i(wb_clk_i),
	.wb_rst_i(wb_rst_i),
	.ack_i(wb_ack_o),
	.error_i(wb_error_o),
	.stall_i(wb_stall_o),
	.sramWriteEnable_i(sramWriteEnable_o),
	.sramReadEnable_i(sramReadEnable_o),
	.mgmtWriteEnable_i(mgmtWriteEnable_o),
	.mgmtReadEnable_i(mgmtReadEnable_o)
);

`default_nettype wire

// ==== tb/wbSramTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module wbSramTb;

	localparam int CLOCK_PERIOD = 40;
	localparam int ACCESS_TIMEOUT = 50;
	localparam int RANDOM_ACCESSES = 400;
	localparam logic [3:0] CORE_ID = 4'd5;

	logic wb_clk_i;
	logic wb_rst_i;
	logic wb_cyc_i;
	logic wb_stb_i;
	logic wb_we_i;
	logic [3:0] wb_sel_i;
	logic [23:0] wb_adr_i;
	logic [31:0] wb_data_i;
	logic [3:0] coreId_i;
	wire wb_ack_o;
	wire wb_stall_o;
	wire wb_error_o;
	wire [31:0] wb_data_o;

	logic [31:0] sramModel [0:wbSramPkg::SRAM_WORDS-1];
	logic [31:0] mgmtModel [0:wbSramPkg::MGMT_REG_COUNT-1];
	logic [31:0] lcgState;
	int errorCount;

	wbSramTop u_wbSramTop (
		.wb_clk_i(wb_clk_i),
		.wb_rst_i(wb_rst_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_we_i(wb_we_i),
		.wb_sel_i(wb_sel_i),
		.wb_adr_i(wb_adr_i),
		.wb_data_i(wb_data_i),
		.wb_ack_o(wb_ack_o),
		.wb_stall_o(wb_stall_o),
		.wb_error_o(wb_error_o),
		.wb_data_o(wb_data_o),
		.coreId_i(coreId_i)
	);

	initial begin
		wb_clk_i = 1'b0;
		forever begin
			#(CLOCK_PERIOD / 2) wb_clk_i = ~wb_clk_i;
		end
	end

	// The output is tempered so that its low bits do not follow the short LCG periods.
	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState ^ (lcgState >> 15);
	endfunction

	function automatic logic [31:0] mergeLanes(input logic [31:0] oldWord,
			input logic [31:0] newWord, input logic [3:0] sel);
		logic [31:0] merged;
		merged = oldWord;
		for (int lane = 0; lane < 4; lane++) begin
			if (sel[lane]) begin
				merged[lane*8 +: 8] = newWord[lane*8 +: 8];
			end
		end
		return merged;
	endfunction

	task automatic failRun();
		$display("FAIL: see errors above");
		$fatal(1, "Simulation stopped after the first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			errorCount++;
			$display("Mismatch %s: got 0x%08h, expected 0x%08h", name, actual, expected);
			failRun();
		end
	endtask

	task automatic reportTimeout(input logic [23:0] adr);
		$display("Timeout: access to address 0x%06h got neither ack nor error in %0d cycles",
			adr, ACCESS_TIMEOUT);
		failRun();
	endtask

	// One Wishbone single access, with the stall and pulse rules checked along the way.
	task automatic runAccess(input logic we, input logic [23:0] adr, input logic [3:0] sel,
			input logic [31:0] data, input logic expectError, output logic [31:0] readData);
		int waitCycles;
		@(negedge wb_clk_i);
		checkValue("wb_stall_o", 32'(wb_stall_o), 32'd0);
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i = we;
		wb_sel_i = sel;
		wb_adr_i = adr;
		wb_data_i = data;
		@(negedge wb_clk_i);
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_sel_i = 4'd0;
		wb_adr_i = 24'd0;
		wb_data_i = 32'd0;
		waitCycles = 0;
		while (!(wb_ack_o || wb_error_o)) begin
			checkValue("wb_stall_o", 32'(wb_stall_o), 32'd1);
			waitCycles++;
			if (waitCycles > ACCESS_TIMEOUT) begin
				reportTimeout(adr);
			end
			@(negedge wb_clk_i);
		end
		checkValue("wb_stall_o", 32'(wb_stall_o), 32'd1);
		checkValue("wb_ack_o", 32'(wb_ack_o), 32'(!expectError));
		checkValue("wb_error_o", 32'(wb_error_o), 32'(expectError));
		readData = wb_data_o;
		@(negedge wb_clk_i);
		checkValue("wb_ack_o", 32'(wb_ack_o), 32'd0);
		checkValue("wb_error_o", 32'(wb_error_o), 32'd0);
		checkValue("wb_stall_o", 32'(wb_stall_o), 32'd0);
	endtask

	task automatic checkedAccess(input logic we, input logic [23:0] adr, input logic [3:0] sel,
			input logic [31:0] data);
		logic isSram;
		logic isMgmt;
		logic [wbSramPkg::SRAM_ADDR_BITS-1:0] wordIndex;
		logic [2:0] regIndex;
		logic [31:0] readData;
		isSram = !adr[23];
		isMgmt = adr[23:20] == wbSramPkg::MGMT_REGION;
		wordIndex = adr[wbSramPkg::SRAM_ADDR_BITS-1:0];
		regIndex = adr[2:0];
		runAccess(we, adr, sel, data, !(isSram || isMgmt), readData);
		if (isSram) begin
			if (we) begin
				sramModel[wordIndex] = mergeLanes(sramModel[wordIndex], data, sel);
			end else begin
				checkValue("wb_data_o", readData, sramModel[wordIndex]);
			end
		end else if (isMgmt) begin
			// The identity word at index 0 ignores writes.
			if (we && regIndex != 3'd0) begin
				mgmtModel[regIndex] = mergeLanes(mgmtModel[regIndex], data, sel);
			end else if (!we) begin
				checkValue("wb_data_o", readData, mgmtModel[regIndex]);
			end
		end
	endtask

	task automatic randomAccess();
		logic [31:0] kind;
		logic [31:0] addrBits;
		logic [31:0] data;
		logic [23:0] adr;
		logic [3:0] nibble;
		kind = nextRandom();
		addrBits = nextRandom();
		data = nextRandom();
		if (kind[31:28] < 4'd10) begin
			adr = {1'b0, addrBits[22:0]};
		end else if (kind[31:28] < 4'd13) begin
			adr = {wbSramPkg::MGMT_REGION, addrBits[19:0]};
		end else begin
			nibble = 4'd9 + {1'b0, kind[26:24] % 3'd7};
			adr = {nibble, addrBits[19:0]};
		end
		checkedAccess(kind[27], adr, kind[23:20], data);
	endtask

	initial begin
		logic [31:0] aliasBits;
		logic [31:0] fillData;
		lcgState = 32'd18;
		errorCount = 0;
		wb_rst_i = 1'b1;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_sel_i = 4'd0;
		wb_adr_i = 24'd0;
		wb_data_i = 32'd0;
		coreId_i = CORE_ID;
		mgmtModel[0] = {28'd0, CORE_ID};
		for (int i = 1; i < wbSramPkg::MGMT_REG_COUNT; i++) begin
			mgmtModel[i] = 32'd0;
		end

		repeat (4) @(posedge wb_clk_i);
		@(negedge wb_clk_i);
		wb_rst_i = 1'b0;
		checkValue("wb_ack_o", 32'(wb_ack_o), 32'd0);
		checkValue("wb_error_o", 32'(wb_error_o), 32'd0);
		checkValue("wb_stall_o", 32'(wb_stall_o), 32'd0);
		checkValue("wb_data_o", wb_data_o, 32'd0);

		// Every SRAM word gets a known value first, through aliased addresses.
		for (int i = 0; i < wbSramPkg::SRAM_WORDS; i++) begin
			aliasBits = nextRandom();
			fillData = nextRandom();
			checkedAccess(1'b1, {1'b0, aliasBits[14:0], 8'(i)}, 4'hF, fillData);
		end

		checkedAccess(1'b0, {wbSramPkg::MGMT_REGION, 20'd0}, 4'hF, 32'd0);
		checkedAccess(1'b1, {wbSramPkg::MGMT_REGION, 20'd0}, 4'hF, nextRandom());
		checkedAccess(1'b0, {wbSramPkg::MGMT_REGION, 20'd0}, 4'hF, 32'd0);
		for (int i = 1; i < wbSramPkg::MGMT_REG_COUNT; i++) begin
			checkedAccess(1'b1, {wbSramPkg::MGMT_REGION, 17'd0, 3'(i)}, 4'hF, nextRandom());
			checkedAccess(1'b0, {wbSramPkg::MGMT_REGION, 17'd0, 3'(i)}, 4'hF, 32'd0);
		end

		checkedAccess(1'b1, 24'h9A0010, 4'hF, 32'hDEADBEEF);
		checkedAccess(1'b0, 24'hF00000, 4'hF, 32'd0);
		checkedAccess(1'b0, 24'h000010, 4'hF, 32'd0);

		for (int i = 0; i < RANDOM_ACCESSES; i++) begin
			randomAccess();
		end

		if (errorCount == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			failRun();
		end
	end

endmodule

`default_nettype wire

// ==== files.f ====
design/wbSramPkg.sv
design/wbSramInterface.sv
design/localSram.sv
design/managementRegs.sv
design/wbSramTop.sv
tb/wbSram_asserts.sv
tb/wbSramTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= wbSramTb
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VERILATOR_FLAGS ?= --timing --assert
FAIL_TEXT ?= FAIL: see errors above
PASS_TEXT ?= PASS: all tests

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BINARY)
	-./$(BINARY) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
